// ==== verilog/exec_cfg.svh ====
`ifndef EXEC_CFG_SVH
`define EXEC_CFG_SVH

// ****************************************
// Execute stage sizing
// ****************************************

// Operand and result width
`define EXEC_DATA_W 32

// Destination register select
`define EXEC_RSEL_W 4

`define EXEC_VEC_W (`EXEC_DATA_W - 6) // Vector base drops the low 6 bits

`endif

// ==== verilog/exec_isa_pkg.sv ====
package exec_isa_pkg;

	// ****************************************
	// ALU operations
	// ****************************************
	typedef enum logic [4:0] {
		ALU_ADD    = 5'd0,
		ALU_ADDC   = 5'd1,
		ALU_SUB    = 5'd2,
		ALU_SUBC   = 5'd3,
		ALU_LSL    = 5'd4,
		ALU_LSR    = 5'd5,
		ALU_AND    = 5'd6,
		ALU_XOR    = 5'd7,
		ALU_BCLR   = 5'd8,
		ALU_BSET   = 5'd9,
		ALU_OR     = 5'd10,
		ALU_MOVB   = 5'd11,
		ALU_CMP    = 5'd12,
		ALU_ORLO   = 5'd13,
		ALU_ASR    = 5'd14,
		ALU_MOVA   = 5'd15,
		ALU_GCR    = 5'd16, // Control register read
		ALU_SWIVEC = 5'd17,
		ALU_FAULT  = 5'd18
	} alu_opc_e;

	typedef enum logic [2:0] {
		BR_NE     = 3'd1,
		BR_EQ     = 3'd2,
		BR_NC     = 3'd3,
		BR_C      = 3'd4,
		BR_ALWAYS = 3'd7 // Codes 0, 5, 6 never taken
	} branch_cond_e;

	typedef enum logic [1:0] {CLASS_ARITH, CLASS_BRANCH, CLASS_LDR, CLASS_STR} instr_class_e;

	typedef enum logic [1:0] {MEM_BYTE, MEM_HALF, MEM_WORD} mem_width_e;

endpackage

// ==== verilog/exec_ctrl_pkg.sv ====
package exec_ctrl_pkg;

	// ****************************************
	// Control register file
	// ****************************************
	typedef enum logic [2:0] {
		CR_VECTOR    = 3'd0, // Exception vector base
		CR_PSR       = 3'd1,
		CR_SAVED_PSR = 3'd2,
		CR_FAULT     = 3'd3
	} cr_sel_e;

	// Processor status, carry above zero
	typedef struct packed {
		logic c;
		logic z;
	} psr_t;

endpackage

// ==== verilog/exec_issue_if.sv ====
`timescale 1ns/1ps
`include "exec_cfg.svh"

// Decoded instruction entering the stage
interface exec_issue_if import exec_isa_pkg::*, exec_ctrl_pkg::*; ();
	logic [`EXEC_DATA_W-1:0] ra;
	logic [`EXEC_DATA_W-1:0] rb;
	logic [`EXEC_DATA_W-1:0] imm32;
	logic [`EXEC_DATA_W-1:0] pc_plus_4;
	logic [`EXEC_RSEL_W-1:0] rd_sel;
	logic update_rd;
	alu_opc_e alu_opc;
	logic op1_ra;
	logic op1_rb;
	logic op2_rb;
	logic mem_load;
	logic mem_store;
	mem_width_e mem_width;
	branch_cond_e branch_cond;
	instr_class_e instr_class;
	logic is_call;
	logic update_flags;
	cr_sel_e cr_sel;
	logic write_cr;
	logic is_swi; // Software interrupt
	logic is_rfe; // Return from exception

	modport issue (
		output ra, rb, imm32, pc_plus_4, rd_sel, update_rd, alu_opc, op1_ra, op1_rb, op2_rb,
		mem_load, mem_store, mem_width, branch_cond, instr_class, is_call, update_flags,
		cr_sel, write_cr, is_swi, is_rfe
	);
	modport exec (
		input ra, rb, imm32, pc_plus_4, rd_sel, update_rd, alu_opc, op1_ra, op1_rb, op2_rb,
		mem_load, mem_store, mem_width, branch_cond, instr_class, is_call, update_flags,
		cr_sel, write_cr, is_swi, is_rfe
	);
endinterface

// Control register state as seen by the ALU
interface exec_ctrl_view_if import exec_ctrl_pkg::*; ();
	psr_t psr;
	logic [`EXEC_DATA_W-1:0] cr_rdata; // Selected by cr_sel
	logic [`EXEC_VEC_W-1:0] vector_base;
	logic [`EXEC_DATA_W-1:0] fault_address;

	modport src (output psr, cr_rdata, vector_base, fault_address);
	modport dst (input psr, cr_rdata, vector_base, fault_address);
endinterface

// ==== verilog/exec_alu.sv ====
`timescale 1ns/1ps
`include "exec_cfg.svh"

module exec_alu import exec_isa_pkg::*; (
	exec_issue_if.exec iss,
	exec_ctrl_view_if.dst cv,
	output logic [`EXEC_DATA_W-1:0] alu_q,
	output logic alu_c,
	output logic alu_z,
	output logic [`EXEC_DATA_W-1:0] op2
);

	logic [`EXEC_DATA_W-1:0] op1;
	logic [`EXEC_DATA_W:0] res; // Carry in the top bit
	logic [`EXEC_DATA_W:0] carry_in;
	logic [4:0] sh;
	logic [`EXEC_DATA_W-1:0] bit_mask;
	logic signed [`EXEC_DATA_W-1:0] asr_q;

	// ****************************************
	// Operand selection
	// ****************************************
	always_comb begin
		if (iss.op1_ra) begin
			op1 = iss.ra;
		end else if (iss.op1_rb) begin
			op1 = iss.rb;
		end else begin
			op1 = iss.pc_plus_4;
		end
	end

	assign op2 = iss.op2_rb ? iss.rb : iss.imm32;

	assign sh = op2[4:0]; // Shift and bit ops use low 5 bits
	assign carry_in = {{`EXEC_DATA_W{1'b0}}, cv.psr.c};
	assign bit_mask = {{(`EXEC_DATA_W-1){1'b0}}, 1'b1} << sh;
	assign asr_q = $signed(op1) >>> sh;

	// ****************************************
	// Operations
	// ****************************************
	always_comb begin
		res = '0;
		case (iss.alu_opc)
			ALU_ADD: res = {1'b0, op1} + {1'b0, op2};
			ALU_ADDC: res = {1'b0, op1} + {1'b0, op2} + carry_in;
			ALU_SUB: res = {1'b0, op1} - {1'b0, op2}; // Borrow lands in carry
			ALU_SUBC: res = {1'b0, op1} - {1'b0, op2} + carry_in;
			ALU_LSL: res = {1'b0, op1} << sh; // Bit shifted out becomes carry
			ALU_LSR: res = {1'b0, op1 >> sh};
			ALU_AND: res = {1'b0, op1 & op2};
			ALU_XOR: res = {1'b0, op1 ^ op2};
			ALU_BCLR: res = {1'b0, op1 & ~bit_mask};
			ALU_BSET: res = {1'b0, op1 | bit_mask};
			ALU_OR: res = {1'b0, op1 | op2};
			ALU_MOVB: res = {1'b0, op2};
			ALU_CMP: res = {1'b0, op1} - {1'b0, op2};
			ALU_ORLO: res = {1'b0, op1 | {{(`EXEC_DATA_W-16){1'b0}}, op2[15:0]}};
			ALU_ASR: res = {1'b0, asr_q};
			ALU_MOVA: res = {1'b0, op1};
			ALU_GCR: res = {1'b0, cv.cr_rdata};
			ALU_SWIVEC: res = {1'b0, cv.vector_base, 6'h08}; // SWI entry in the table
			ALU_FAULT: res = {1'b0, cv.fault_address};
			default: res = '0;
		endcase
	end

	assign alu_q = res[`EXEC_DATA_W-1:0];
	assign alu_c = res[`EXEC_DATA_W];

	// Equality of operands, not of the result
	assign alu_z = (op1 == op2);

endmodule

// ==== verilog/exec_ctrl_regs.sv ====
`timescale 1ns/1ps
`include "exec_cfg.svh"

module exec_ctrl_regs import exec_isa_pkg::*, exec_ctrl_pkg::*; (
	input logic clk,
	input logic rst,
	exec_issue_if.exec iss,
	input logic alu_c,
	input logic alu_z,
	exec_ctrl_view_if.src cv,
	output logic cond_met
);

	psr_t psr; // CR1, the live flags
	psr_t saved_psr; // CR2
	logic [`EXEC_VEC_W-1:0] vector_addr; // CR0
	logic [`EXEC_DATA_W-1:0] fault_addr; // CR3

	// ****************************************
	// Flags and control registers
	// ****************************************
	always_ff @(posedge clk) begin
		if (rst) begin
			psr <= '0;
		end else if (iss.write_cr && iss.cr_sel == CR_PSR) begin
			psr <= psr_t'(iss.ra[1:0]);
		end else if (iss.is_rfe) begin
			psr <= saved_psr; // Restore on exception return
		end else if (iss.update_flags) begin
			psr <= '{c: alu_c, z: alu_z};
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			vector_addr <= '0;
		end else if (iss.write_cr && iss.cr_sel == CR_VECTOR) begin
			vector_addr <= iss.ra[`EXEC_DATA_W-1:`EXEC_DATA_W-`EXEC_VEC_W];
		end
	end

	// SWI wins over a software write to CR2 and CR3
	always_ff @(posedge clk) begin
		if (rst) begin
			saved_psr <= '0;
			fault_addr <= '0;
		end else if (iss.is_swi) begin
			saved_psr <= psr;
			fault_addr <= iss.pc_plus_4; // Return address
		end else if (iss.write_cr) begin
			if (iss.cr_sel == CR_SAVED_PSR) begin
				saved_psr <= psr_t'(iss.ra[1:0]);
			end
			if (iss.cr_sel == CR_FAULT) begin
				fault_addr <= iss.ra;
			end
		end
	end

	// ****************************************
	// Read side
	// ****************************************
	always_comb begin
		case (iss.cr_sel)
			CR_VECTOR: cv.cr_rdata = {vector_addr, {(`EXEC_DATA_W-`EXEC_VEC_W){1'b0}}};
			CR_PSR: cv.cr_rdata = {{(`EXEC_DATA_W-2){1'b0}}, psr};
			CR_SAVED_PSR: cv.cr_rdata = {{(`EXEC_DATA_W-2){1'b0}}, saved_psr};
			CR_FAULT: cv.cr_rdata = fault_addr;
			default: cv.cr_rdata = '0; // Unimplemented registers
		endcase
	end

	assign cv.psr = psr;
	assign cv.vector_base = vector_addr;
	assign cv.fault_address = fault_addr;

	always_comb begin
		case (iss.branch_cond)
			BR_NE: cond_met = !psr.z;
			BR_EQ: cond_met = psr.z;
			BR_NC: cond_met = !psr.c;
			BR_C: cond_met = psr.c;
			BR_ALWAYS: cond_met = 1'b1;
			default: cond_met = 1'b0;
		endcase
	end

endmodule

// ==== verilog/exec_result_reg.sv ====
`timescale 1ns/1ps
`include "exec_cfg.svh"

module exec_result_reg import exec_isa_pkg::*; (
	input logic clk,
	input logic rst,
	exec_issue_if.exec iss,
	input logic [`EXEC_DATA_W-1:0] alu_q,
	input logic [`EXEC_DATA_W-1:0] op2,
	input logic cond_met,
	output logic [`EXEC_DATA_W-1:0] alu_out,
	output logic [`EXEC_DATA_W-1:0] wr_val,
	output logic wr_result,
	output logic [`EXEC_RSEL_W-1:0] rd_sel_out,
	output logic branch_taken,
	output logic stall_clear,
	output logic mem_load_out,
	output logic mem_store_out,
	output mem_width_e mem_width_out,
	output logic [`EXEC_DATA_W-1:0] mar,
	output logic [`EXEC_DATA_W-1:0] mdr,
	output logic mem_wr_en
);

	logic is_branch;

	assign is_branch = (iss.instr_class == CLASS_BRANCH);

	// ****************************************
	// Writeback and branch results
	// ****************************************
	always_ff @(posedge clk) begin
		if (rst) begin
			alu_out <= '0;
			wr_val <= '0;
			wr_result <= 1'b0;
			rd_sel_out <= '0;
			branch_taken <= 1'b0;
			stall_clear <= 1'b0;
		end else begin
			alu_out <= alu_q;
			wr_result <= iss.update_rd;
			rd_sel_out <= iss.rd_sel;
			if (iss.is_call) begin
				wr_val <= iss.pc_plus_4; // Link address
			end else if (iss.mem_store) begin
				wr_val <= op2;
			end else begin
				wr_val <= alu_q;
			end
			branch_taken <= is_branch && (cond_met || iss.is_swi || iss.is_rfe);
			stall_clear <= is_branch;
		end
	end

	// ****************************************
	// Memory request
	// ****************************************
	always_ff @(posedge clk) begin
		if (rst) begin
			mem_load_out <= 1'b0;
			mem_store_out <= 1'b0;
			mem_wr_en <= 1'b0;
			mem_width_out <= MEM_BYTE;
			mar <= '0;
			mdr <= '0;
		end else begin
			mem_load_out <= iss.mem_load;
			mem_store_out <= iss.mem_store;
			mem_wr_en <= iss.mem_store;
			if (iss.mem_load || iss.mem_store) begin
				mem_width_out <= iss.mem_width;
				mar <= alu_q; // Effective address
			end
			if (iss.mem_store) begin
				mdr <= iss.rb;
			end
		end
	end

endmodule

// ==== verilog/exec_stage.sv ====
`timescale 1ns/1ps
`include "exec_cfg.svh"

module exec_stage import exec_isa_pkg::*, exec_ctrl_pkg::*; (
	input logic clk,
	input logic rst,
	input logic [`EXEC_DATA_W-1:0] ra,
	input logic [`EXEC_DATA_W-1:0] rb,
	input logic [`EXEC_DATA_W-1:0] imm32,
	input logic [`EXEC_DATA_W-1:0] pc_plus_4,
	input logic [`EXEC_RSEL_W-1:0] rd_sel,
	input logic update_rd,
	input alu_opc_e alu_opc,
	input logic op1_ra,
	input logic op1_rb,
	input logic op2_rb,
	input logic mem_load,
	input logic mem_store,
	input mem_width_e mem_width,
	input branch_cond_e branch_cond,
	input instr_class_e instr_class,
	input logic is_call,
	input logic update_flags,
	input cr_sel_e cr_sel,
	input logic write_cr,
	input logic is_swi,
	input logic is_rfe,
	output logic [`EXEC_DATA_W-1:0] alu_out,
	output logic [`EXEC_DATA_W-1:0] wr_val,
	output logic wr_result,
	output logic [`EXEC_RSEL_W-1:0] rd_sel_out,
	output logic branch_taken,
	output logic stall_clear,
	output logic mem_load_out,
	output logic mem_store_out,
	output mem_width_e mem_width_out,
	output logic [`EXEC_DATA_W-1:0] mar,
	output logic [`EXEC_DATA_W-1:0] mdr,
	output logic mem_wr_en,
	output logic [`EXEC_VEC_W-1:0] vector_base
);

	logic [`EXEC_DATA_W-1:0] alu_q;
	logic alu_c;
	logic alu_z;
	logic [`EXEC_DATA_W-1:0] op2;
	logic cond_met;

	exec_issue_if iss ();
	exec_ctrl_view_if cv ();

	// ****************************************
	// Issue bundle from the decode ports
	// ****************************************
	assign iss.ra = ra;
	assign iss.rb = rb;
	assign iss.imm32 = imm32;
	assign iss.pc_plus_4 = pc_plus_4;
	assign iss.rd_sel = rd_sel;
	assign iss.update_rd = update_rd;
	assign iss.alu_opc = alu_opc;
	assign iss.op1_ra = op1_ra;
	assign iss.op1_rb = op1_rb;
	assign iss.op2_rb = op2_rb;
	assign iss.mem_load = mem_load;
	assign iss.mem_store = mem_store;
	assign iss.mem_width = mem_width;
	assign iss.branch_cond = branch_cond;
	assign iss.instr_class = instr_class;
	assign iss.is_call = is_call;
	assign iss.update_flags = update_flags;
	assign iss.cr_sel = cr_sel;
	assign iss.write_cr = write_cr;
	assign iss.is_swi = is_swi;
	assign iss.is_rfe = is_rfe;

	assign vector_base = cv.vector_base; // CR0, not pipelined

	exec_alu i_alu (.iss(iss), .cv(cv), .alu_q, .alu_c, .alu_z, .op2);

	exec_ctrl_regs i_ctrl_regs (.clk, .rst, .iss(iss), .alu_c, .alu_z, .cv(cv), .cond_met);

	exec_result_reg i_result_reg (
		.clk, .rst, .iss(iss), .alu_q, .op2, .cond_met,
		.alu_out, .wr_val, .wr_result, .rd_sel_out, .branch_taken, .stall_clear,
		.mem_load_out, .mem_store_out, .mem_width_out, .mar, .mdr, .mem_wr_en
	);

endmodule

// ==== tb/exec_assertions.sv ====
`timescale 1ns/1ps
`include "exec_cfg.svh"

module exec_assertions (
	input logic clk,
	input logic rst,
	input logic mem_store,
	input logic branch_taken,
	input logic stall_clear,
	input logic wr_result,
	input logic mem_load_out,
	input logic mem_store_out,
	input logic mem_wr_en,
	input logic [`EXEC_DATA_W-1:0] mdr
);

	int fail_count = 0; // Polled by the testbench

	// ****************************************
	// Output rules
	// ****************************************
	a_wr_en: assert property (@(posedge clk) mem_wr_en == mem_store_out)
		else begin
			fail_count++;
			$error("mem_wr_en differs from mem_store_out");
		end

	a_taken_clears: assert property (@(posedge clk) branch_taken |-> stall_clear)
		else begin
			fail_count++;
			$error("branch_taken without stall_clear");
		end

	// Strobes after a reset edge
	a_reset_low: assert property (@(posedge clk) $past(rst) |->
		!(branch_taken || stall_clear || wr_result || mem_load_out || mem_store_out || mem_wr_en))
		else begin
			fail_count++;
			$error("control strobe high after reset");
		end

	a_mdr_hold: assert property (@(posedge clk) !$stable(mdr) |-> ($past(mem_store) || $past(rst)))
		else begin
			fail_count++;
			$error("mdr changed without a store");
		end

endmodule

bind exec_stage exec_assertions i_assertions (
	.clk(clk), .rst(rst), .mem_store(mem_store), .branch_taken(branch_taken),
	.stall_clear(stall_clear), .wr_result(wr_result), .mem_load_out(mem_load_out),
	.mem_store_out(mem_store_out), .mem_wr_en(mem_wr_en), .mdr(mdr)
);

// ==== tb/exec_tb.sv ====
`timescale 1ns/1ps
`include "exec_cfg.svh"

module exec_tb import exec_isa_pkg::*, exec_ctrl_pkg::*; #(
	parameter logic [31:0] seed = 32'hd442a06c
) ();

	localparam int num_instr = 4000;
	localparam int reset_at = 2000; // Mid-run reset point
	localparam int max_cycles = 4200;

	logic clk = 1'b0;
	logic rst;
	logic [`EXEC_DATA_W-1:0] ra, rb, imm32, pc_plus_4;
	logic [`EXEC_RSEL_W-1:0] rd_sel;
	logic update_rd, op1_ra, op1_rb, op2_rb, mem_load, mem_store, is_call;
	logic update_flags, write_cr, is_swi, is_rfe;
	alu_opc_e alu_opc;
	mem_width_e mem_width;
	branch_cond_e branch_cond;
	instr_class_e instr_class;
	cr_sel_e cr_sel;
	logic [`EXEC_DATA_W-1:0] alu_out, wr_val, mar, mdr;
	logic [`EXEC_RSEL_W-1:0] rd_sel_out;
	logic wr_result, branch_taken, stall_clear, mem_load_out, mem_store_out, mem_wr_en;
	mem_width_e mem_width_out;
	logic [`EXEC_VEC_W-1:0] vector_base;

	// Reference model state and expected outputs
	psr_t m_psr, m_saved, e_psr;
	logic [`EXEC_VEC_W-1:0] m_vec;
	logic [31:0] m_fault, e_alu, e_wr_val, e_mar, e_mdr;
	logic [3:0] e_rd_sel;
	logic e_wr_result, e_bt, e_sc, e_ld, e_st, e_psr_chk;
	mem_width_e e_width;
	int n_taken = 0;
	int n_swi = 0;
	int n_psr_reads = 0;
	int sweep = 0; // GCR reads of CR0..CR3 after the mid-run reset

	exec_stage i_dut (.*);

	always #4 clk = ~clk;

	task automatic stop_run();
		$display("tests failed");
		$fatal(1, "run stopped at the first error");
	endtask

	// ****************************************
	// Compare tasks
	// ****************************************
	task automatic check_word(string name, logic [31:0] exp, logic [31:0] act);
		if (exp !== act) begin
			$display("[ERROR] %s expected %h actual %h", name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_bit(string name, logic exp, logic act);
		if (exp !== act) begin
			$display("[ERROR] %s expected %b actual %b", name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_rsel(string name, logic [`EXEC_RSEL_W-1:0] exp,
		logic [`EXEC_RSEL_W-1:0] act);
		if (exp !== act) begin
			$display("[ERROR] %s expected %0d actual %0d", name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_width(string name, mem_width_e exp, mem_width_e act);
		if (exp !== act) begin
			$display("[ERROR] %s expected %0d actual %0d", name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_psr(string name, psr_t exp, psr_t act);
		if (exp !== act) begin
			$display("[ERROR] %s expected c=%b z=%b actual c=%b z=%b", name, exp.c, exp.z,
				act.c, act.z);
			stop_run();
		end
	endtask

	// ****************************************
	// Reference model
	// ****************************************
	function automatic logic [31:0] cr_value(cr_sel_e sel);
		case (sel)
			CR_VECTOR: return {m_vec, 6'd0};
			CR_PSR: return {30'd0, m_psr};
			CR_SAVED_PSR: return {30'd0, m_saved};
			CR_FAULT: return m_fault;
			default: return 32'd0;
		endcase
	endfunction

	function automatic logic cond_taken(branch_cond_e cond);
		case (cond)
			BR_NE: return !m_psr.z;
			BR_EQ: return m_psr.z;
			BR_NC: return !m_psr.c;
			BR_C: return m_psr.c;
			BR_ALWAYS: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	// Result with carry in bit 32
	function automatic logic [32:0] alu_ref(alu_opc_e opc, cr_sel_e sel, logic [31:0] a,
		logic [31:0] b);
		logic [4:0] n;
		logic [63:0] wide;
		n = b[4:0];
		wide = {32'd0, a} << n;
		case (opc)
			ALU_ADD: return 33'(a) + 33'(b);
			ALU_ADDC: return 33'(a) + 33'(b) + 33'(m_psr.c);
			ALU_SUB, ALU_CMP: return 33'(a) - 33'(b);
			ALU_SUBC: return 33'(a) - 33'(b) + 33'(m_psr.c);
			ALU_LSL: return wide[32:0];
			ALU_LSR: return {1'b0, a >> n};
			ALU_ASR: return {1'b0, (a >> n) | (a[31] ? ~(32'hffffffff >> n) : 32'd0)};
			ALU_AND: return {1'b0, a & b};
			ALU_XOR: return {1'b0, a ^ b};
			ALU_OR: return {1'b0, a | b};
			ALU_BCLR: return {1'b0, a & ~(32'd1 << n)};
			ALU_BSET: return {1'b0, a | (32'd1 << n)};
			ALU_MOVB: return {1'b0, b};
			ALU_ORLO: return {1'b0, a | {16'd0, b[15:0]}};
			ALU_MOVA: return {1'b0, a};
			ALU_GCR: return {1'b0, cr_value(sel)};
			ALU_SWIVEC: return {1'b0, m_vec, 6'h08};
			ALU_FAULT: return {1'b0, m_fault};
			default: return 33'd0;
		endcase
	endfunction

	task automatic clear_model();
		m_psr = '0;
		m_saved = '0;
		m_vec = '0;
		m_fault = '0;
		{e_alu, e_wr_val, e_mar, e_mdr, e_rd_sel} = '0;
		{e_wr_result, e_bt, e_sc, e_ld, e_st, e_psr_chk} = '0;
		e_width = MEM_BYTE;
		e_psr = '0;
	endtask

	task automatic idle_inputs();
		{ra, rb, imm32, pc_plus_4, rd_sel} = '0;
		{update_rd, op1_ra, op1_rb, op2_rb, mem_load, mem_store, is_call} = '0;
		{update_flags, write_cr, is_swi, is_rfe} = '0;
		alu_opc = ALU_ADD;
		mem_width = MEM_BYTE;
		branch_cond = branch_cond_e'(3'd0);
		instr_class = CLASS_ARITH;
		cr_sel = CR_VECTOR;
	endtask

	task automatic apply_reset();
		int wait_cnt;
		rst = 1'b1;
		idle_inputs();
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		clear_model();
		wait_cnt = 0;
		while (rst || stall_clear || branch_taken || wr_result || mem_load_out || mem_wr_en) begin
			wait_cnt++;
			if (wait_cnt > 20) begin
				$display("Timeout: control outputs did not go low after reset");
				stop_run();
			end
			@(negedge clk);
		end
	endtask

	task automatic check_outputs();
		check_word("alu_out", e_alu, alu_out);
		check_word("wr_val", e_wr_val, wr_val);
		check_bit("wr_result", e_wr_result, wr_result);
		check_rsel("rd_sel_out", e_rd_sel, rd_sel_out);
		check_bit("branch_taken", e_bt, branch_taken);
		check_bit("stall_clear", e_sc, stall_clear);
		check_bit("mem_load_out", e_ld, mem_load_out);
		check_bit("mem_store_out", e_st, mem_store_out);
		check_bit("mem_wr_en", e_st, mem_wr_en);
		check_width("mem_width_out", e_width, mem_width_out);
		check_word("mar", e_mar, mar);
		check_word("mdr", e_mdr, mdr);
		check_word("vector_base", {m_vec, 6'd0}, {vector_base, 6'd0});
		if (e_psr_chk) begin
			check_psr("gcr_psr", e_psr, psr_t'(alu_out[1:0]));
		end
		if (i_dut.i_assertions.fail_count != 0) begin
			$display("A bound assertion on the stage outputs failed");
			stop_run();
		end
	endtask

	// ****************************************
	// Stimulus
	// ****************************************
	task automatic issue_instr();
		logic [31:0] r0, r1, a, b;
		logic [32:0] q;
		psr_t old_saved;
		r0 = $urandom();
		r1 = $urandom();
		ra = $urandom();
		rb = (r0[2:0] == 3'd0) ? ra : $urandom(); // Equal operands now and then
		imm32 = (r0[5:3] == 3'd0) ? ra : $urandom();
		pc_plus_4 = $urandom() & 32'hfffffffc;
		rd_sel = r0[9:6];
		update_rd = r0[10];
		alu_opc = alu_opc_e'((r0[12:11] == 2'd0) ? 5'd16 : r0[17:13]);
		op1_ra = r0[18];
		op1_rb = r0[19];
		op2_rb = r0[20];
		instr_class = instr_class_e'(r0[22:21]);
		mem_load = (instr_class == CLASS_LDR);
		mem_store = (instr_class == CLASS_STR);
		mem_width = mem_width_e'((r0[24:23] == 2'd3) ? 2'd2 : r0[24:23]);
		branch_cond = branch_cond_e'(r0[27:25]);
		is_call = r1[0] & r1[1];
		update_flags = r1[2];
		cr_sel = cr_sel_e'(r1[5:3]);
		write_cr = (r1[8:6] == 3'd0);
		is_swi = (r1[11:9] == 3'd0);
		is_rfe = (r1[14:12] == 3'd0);
		if (sweep > 0) begin
			alu_opc = ALU_GCR;
			cr_sel = cr_sel_e'(3'(4 - sweep));
			{update_flags, write_cr, is_swi, is_rfe} = '0;
			sweep--;
		end
		a = op1_ra ? ra : (op1_rb ? rb : pc_plus_4);
		b = op2_rb ? rb : imm32;
		q = alu_ref(alu_opc, cr_sel, a, b);
		e_alu = q[31:0];
		e_wr_val = is_call ? pc_plus_4 : (mem_store ? b : q[31:0]);
		e_wr_result = update_rd;
		e_rd_sel = rd_sel;
		e_sc = (instr_class == CLASS_BRANCH);
		e_bt = e_sc && (cond_taken(branch_cond) || is_swi || is_rfe);
		e_ld = mem_load;
		e_st = mem_store;
		if (mem_load || mem_store) begin
			e_width = mem_width;
			e_mar = q[31:0];
		end
		if (mem_store) begin
			e_mdr = rb;
		end
		e_psr_chk = (alu_opc == ALU_GCR) && (cr_sel == CR_PSR || cr_sel == CR_SAVED_PSR);
		e_psr = (cr_sel == CR_PSR) ? m_psr : m_saved;
		n_taken += int'(e_bt);
		n_swi += int'(is_swi);
		n_psr_reads += int'(e_psr_chk);
		old_saved = m_saved; // RFE restores the value from before this edge
		if (is_swi) begin
			m_saved = m_psr; // Old PSR, the flag update comes below
			m_fault = pc_plus_4;
		end else if (write_cr && cr_sel == CR_SAVED_PSR) begin
			m_saved = psr_t'(ra[1:0]);
		end else if (write_cr && cr_sel == CR_FAULT) begin
			m_fault = ra;
		end
		if (write_cr && cr_sel == CR_PSR) begin
			m_psr = psr_t'(ra[1:0]);
		end else if (is_rfe) begin
			m_psr = old_saved;
		end else if (update_flags) begin
			m_psr = '{c: q[32], z: (a == b)};
		end
		if (write_cr && cr_sel == CR_VECTOR) begin
			m_vec = ra[31:6];
		end
	endtask

	initial begin
		int issued;
		int cycles;
		void'($urandom(seed));
		apply_reset();
		check_outputs();
		issued = 0;
		cycles = 0;
		while (issued < num_instr) begin
			cycles++;
			if (cycles > max_cycles) begin
				$display("Timeout: run loop did not finish the instruction stream");
				stop_run();
			end
			if (issued == reset_at) begin
				apply_reset();
				check_outputs();
				sweep = 4;
			end
			issue_instr();
			@(negedge clk);
			check_outputs();
			issued++;
		end
		if (n_taken == 0 || n_swi == 0 || n_psr_reads == 0) begin
			$display("Stimulus never reached taken branches, SWI or PSR reads");
			$display("tests failed");
			$fatal(1, "coverage hole in the random stream");
		end else begin
			$display("all tests passed");
			$finish;
		end
	end

endmodule

// ==== sim.f ====
+incdir+verilog
verilog/exec_isa_pkg.sv
verilog/exec_ctrl_pkg.sv
verilog/exec_issue_if.sv
verilog/exec_alu.sv
verilog/exec_ctrl_regs.sv
verilog/exec_result_reg.sv
verilog/exec_stage.sv
tb/exec_assertions.sv
tb/exec_tb.sv

// ==== Makefile ====
# Verilator build and run of the execute stage testbench

TOP       ?= exec_tb
SEED      ?= 32'hd442a06c
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) "-Gseed=$(SEED)" -f sim.f \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) +verilator+error+limit+100 > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "tests failed" $(LOG); then echo "FAIL: see $(LOG)"; exit 1; fi
	@if ! grep -q "all tests passed" $(LOG); then echo "FAIL: no pass line in $(LOG)"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
